//--- source/vc_router_pkg.sv
// shared constants and types of the virtual-channel router
// port and VC counts, index types, flit struct

`default_nettype none

package vc_router_pkg;

  // ====================
  // sizes
  // ====================

  // physical ports, every port is both input and output
  localparam int NumPorts = 4;
  // virtual channels per physical port
  localparam int NumVC = 2;
  // payload bits carried by one flit
  localparam int DataWidth = 16;

  // ====================
  // types
  // ====================

  typedef logic [$clog2(NumPorts)-1:0] port_idx_t;
  typedef logic [$clog2(NumVC)-1:0] vc_idx_t;

  // routing is a field read, the output port travels with the flit
  // the vc id is kept on every hop
  typedef struct packed {
    port_idx_t              dst_port;
    vc_idx_t                vc_id;
    logic [DataWidth-1:0]   payload;
  } flit_t;

endpackage

`default_nettype wire

//--- source/vc_buffer.sv
// circular FIFO for one virtual channel
// payload type is a parameter, head is shown as soon as it is stored

`timescale 1ns/1ps
`default_nettype none

module vc_buffer #(
  parameter int  VCDepth   = 2,
  parameter type payload_t = logic
) (
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  logic     push_i,
  input  payload_t data_i,
  input  logic     pop_i,
  output logic     valid_o,
  output payload_t data_o
);

  localparam int PtrWidth = (VCDepth > 1) ? $clog2(VCDepth) : 1;
  localparam int CntWidth = $clog2(VCDepth + 1);

  typedef logic [PtrWidth-1:0] ptr_t;

  payload_t            mem_q [VCDepth];
  ptr_t                rd_ptr_q;
  ptr_t                wr_ptr_q;
  logic [CntWidth-1:0] count_q;

  // wrap at VCDepth, which need not be a power of two
  function automatic ptr_t ptr_inc(ptr_t ptr);
    return (ptr == ptr_t'(VCDepth - 1)) ? '0 : ptr + 1'b1;
  endfunction

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= ptr_inc(wr_ptr_q);
      end
      if (pop_i) begin
        rd_ptr_q <= ptr_inc(rd_ptr_q);
      end
      if (push_i && !pop_i) begin
        count_q <= count_q + 1'b1;
      end else if (pop_i && !push_i) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  assign valid_o = (count_q != '0);
  assign data_o  = mem_q[rd_ptr_q];

  // upstream may only send while it holds a credit for this VC
  a_no_overflow : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    push_i |-> (count_q < VCDepth))
    else $error("vc_buffer: push into a full buffer");

  a_no_underflow : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    pop_i |-> valid_o)
    else $error("vc_buffer: pop from an empty buffer");

endmodule

`default_nettype wire

//--- source/vc_input_port.sv
// one router input port
// one buffer per VC, head flit outputs, credit pulse for every read

`timescale 1ns/1ps
`default_nettype none

module vc_input_port import vc_router_pkg::*; #(
  parameter int VCDepth = 2
) (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic                data_v_i,
  input  flit_t               data_i,
  input  logic                read_v_i,
  input  logic [NumVC-1:0]    read_vc_oh_i,
  output logic [NumVC-1:0]    head_v_o,
  output flit_t [NumVC-1:0]   head_o,
  output logic                credit_v_o,
  output vc_idx_t             credit_id_o
);

  vc_idx_t read_vc_idx;
  logic    credit_v_q;
  vc_idx_t credit_id_q;

  // steer by vc_id, pop the VC picked by the allocators
  for (genvar v = 0; v < NumVC; v++) begin : gen_vc
    vc_buffer #(
      .VCDepth   ( VCDepth ),
      .payload_t ( flit_t  )
    ) i_vc_buffer (
      .clk_i   ( clk_i                                        ),
      .rst_n_i ( rst_n_i                                      ),
      .push_i  ( data_v_i && (data_i.vc_id == vc_idx_t'(v))   ),
      .data_i  ( data_i                                       ),
      .pop_i   ( read_v_i && read_vc_oh_i[v]                  ),
      .valid_o ( head_v_o[v]                                  ),
      .data_o  ( head_o[v]                                    )
    );
  end

  // one-hot to index for the credit id
  always_comb begin
    read_vc_idx = '0;
    for (int v = 0; v < NumVC; v++) begin
      if (read_vc_oh_i[v]) begin
        read_vc_idx = vc_idx_t'(v);
      end
    end
  end

  // the pulse lines up with the flit leaving the ST stage
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      credit_v_q <= 1'b0;
    end else begin
      credit_v_q <= read_v_i;
    end
  end

  always_ff @(posedge clk_i) begin
    credit_id_q <= read_vc_idx;
  end

  assign credit_v_o  = credit_v_q;
  assign credit_id_o = credit_id_q;

  // a grant always names exactly one VC that holds a flit
  a_read_oh : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    read_v_i |-> ($onehot(read_vc_oh_i) && |(read_vc_oh_i & head_v_o)))
    else $error("vc_input_port: bad read VC select");

endmodule

`default_nettype wire

//--- source/sa_local.sv
// local switch allocation of one input port
// round-robin over VCs whose head flit has a downstream credit

`timescale 1ns/1ps
`default_nettype none

module sa_local import vc_router_pkg::*; (
  input  logic                            clk_i,
  input  logic                            rst_n_i,
  input  logic [NumVC-1:0]                head_v_i,
  input  flit_t [NumVC-1:0]               head_i,
  input  logic [NumPorts-1:0][NumVC-1:0]  vc_not_full_i,
  input  logic                            sent_i,
  output logic [NumPorts-1:0]             req_o,
  output logic [NumVC-1:0]                vc_oh_o
);

  logic [NumVC-1:0] eligible;
  vc_idx_t          rr_ptr_q;
  vc_idx_t          win_idx;
  logic             win_v;

  // head present and the target output has room on that VC
  for (genvar v = 0; v < NumVC; v++) begin : gen_eligible
    assign eligible[v] = head_v_i[v] && vc_not_full_i[head_i[v].dst_port][head_i[v].vc_id];
  end

  // first eligible VC at or after the pointer wins
  always_comb begin
    int idx;
    win_idx = rr_ptr_q;
    win_v   = 1'b0;
    for (int i = 0; i < NumVC; i++) begin
      idx = (int'(rr_ptr_q) + i) % NumVC;
      if (!win_v && eligible[idx]) begin
        win_v   = 1'b1;
        win_idx = vc_idx_t'(idx);
      end
    end
  end

  always_comb begin
    req_o   = '0;
    vc_oh_o = '0;
    if (win_v) begin
      req_o[head_i[win_idx].dst_port] = 1'b1;
      vc_oh_o[win_idx]                = 1'b1;
    end
  end

  // only move on when the global stage actually took the flit
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rr_ptr_q <= '0;
    end else if (sent_i) begin
      rr_ptr_q <= vc_idx_t'((int'(win_idx) + 1) % NumVC);
    end
  end

endmodule

`default_nettype wire

//--- source/sa_global.sv
// global switch allocation of one output port
// round-robin over the inputs that request this output

`timescale 1ns/1ps
`default_nettype none

module sa_global import vc_router_pkg::*; (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic [NumPorts-1:0] req_i,
  output logic                gnt_v_o,
  output logic [NumPorts-1:0] gnt_oh_o
);

  port_idx_t rr_ptr_q;
  port_idx_t win_idx;
  logic      win_v;

  // first requester at or after the pointer gets the output
  always_comb begin
    int idx;
    win_idx = rr_ptr_q;
    win_v   = 1'b0;
    for (int i = 0; i < NumPorts; i++) begin
      idx = (int'(rr_ptr_q) + i) % NumPorts;
      if (!win_v && req_i[idx]) begin
        win_v   = 1'b1;
        win_idx = port_idx_t'(idx);
      end
    end
  end

  always_comb begin
    gnt_oh_o = '0;
    if (win_v) begin
      gnt_oh_o[win_idx] = 1'b1;
    end
  end

  assign gnt_v_o = win_v;

  // winner drops to lowest priority
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rr_ptr_q <= '0;
    end else if (win_v) begin
      rr_ptr_q <= port_idx_t'((int'(win_idx) + 1) % NumPorts);
    end
  end

  // an input passed over in one grant is served before the winner repeats
  a_rr_fair : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (gnt_v_o && |(req_i & ~gnt_oh_o))
      |=> !(gnt_oh_o == $past(gnt_oh_o) && |(req_i & $past(req_i & ~gnt_oh_o))))
    else $error("sa_global: same input granted twice while another waited");

endmodule

`default_nettype wire

//--- source/credit_counter.sv
// downstream credit counters of one output port
// one counter per VC, reset to the full buffer depth

`timescale 1ns/1ps
`default_nettype none

module credit_counter import vc_router_pkg::*; #(
  parameter int VCDepth = 2
) (
  input  logic             clk_i,
  input  logic             rst_n_i,
  input  logic             credit_v_i,
  input  vc_idx_t          credit_id_i,
  input  logic             consume_v_i,
  input  vc_idx_t          consume_id_i,
  output logic [NumVC-1:0] vc_not_full_o
);

  localparam int CntWidth = $clog2(VCDepth + 1);

  logic [NumVC-1:0][CntWidth-1:0] count_q;

  for (genvar v = 0; v < NumVC; v++) begin : gen_cnt
    logic inc;
    logic dec;

    assign inc = credit_v_i && (credit_id_i == vc_idx_t'(v));
    assign dec = consume_v_i && (consume_id_i == vc_idx_t'(v));

    // return and consume in one cycle cancel out
    always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
        count_q[v] <= CntWidth'(VCDepth);
      end else if (inc && !dec) begin
        count_q[v] <= count_q[v] + 1'b1;
      end else if (dec && !inc) begin
        count_q[v] <= count_q[v] - 1'b1;
      end
    end

    assign vc_not_full_o[v] = (count_q[v] != '0);
  end

  // SA only grants a VC that has credit left
  a_no_underflow : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    consume_v_i |-> (count_q[consume_id_i] != '0))
    else $error("credit_counter: consume without credit");

  a_no_excess : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (credit_v_i && !(consume_v_i && consume_id_i == credit_id_i))
      |-> (count_q[credit_id_i] < VCDepth))
    else $error("credit_counter: more credits returned than slots");

endmodule

`default_nettype wire

//--- source/st_switch.sv
// SA to ST stage register and the output crossbar
// each output registers the flit of its granted input and VC

`timescale 1ns/1ps
`default_nettype none

module st_switch import vc_router_pkg::*; (
  input  logic                                clk_i,
  input  logic                                rst_n_i,
  input  logic [NumPorts-1:0]                 gnt_v_i,
  input  logic [NumPorts-1:0][NumPorts-1:0]   gnt_oh_i,
  input  logic [NumPorts-1:0][NumVC-1:0]      read_vc_oh_i,
  input  flit_t [NumPorts-1:0][NumVC-1:0]     head_i,
  output logic [NumPorts-1:0]                 data_v_o,
  output flit_t [NumPorts-1:0]                data_o
);

  flit_t [NumPorts-1:0] sel_flit;
  logic  [NumPorts-1:0] data_v_q;
  flit_t [NumPorts-1:0] data_q;

  // gnt_oh_i is indexed [output][input], read_vc_oh_i per input
  always_comb begin
    sel_flit = '0;
    for (int o = 0; o < NumPorts; o++) begin
      for (int i = 0; i < NumPorts; i++) begin
        for (int v = 0; v < NumVC; v++) begin
          if (gnt_oh_i[o][i] && read_vc_oh_i[i][v]) begin
            sel_flit[o] = head_i[i][v];
          end
        end
      end
    end
  end

  // ====================
  // ST stage register
  // ====================

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      data_v_q <= '0;
    end else begin
      data_v_q <= gnt_v_i;
    end
  end

  always_ff @(posedge clk_i) begin
    data_q <= sel_flit;
  end

  assign data_v_o = data_v_q;
  assign data_o   = data_q;

endmodule

`default_nettype wire

//--- source/vc_router.sv
// top level of the virtual-channel router
// input ports, local and global SA, credit counters, ST switch
// two stages: SA in the grant cycle, ST one cycle later

`timescale 1ns/1ps
`default_nettype none

module vc_router import vc_router_pkg::*; #(
  parameter int VCDepth = 2
) (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  // upstream links
  input  logic [NumPorts-1:0]     data_v_i,
  input  flit_t [NumPorts-1:0]    data_i,
  output logic [NumPorts-1:0]     credit_v_o,
  output vc_idx_t [NumPorts-1:0]  credit_id_o,
  // downstream links
  output logic [NumPorts-1:0]     data_v_o,
  output flit_t [NumPorts-1:0]    data_o,
  input  logic [NumPorts-1:0]     credit_v_i,
  input  vc_idx_t [NumPorts-1:0]  credit_id_i
);

  logic  [NumPorts-1:0][NumVC-1:0]    head_v;
  flit_t [NumPorts-1:0][NumVC-1:0]    head;
  logic  [NumPorts-1:0][NumVC-1:0]    vc_not_full;
  // [input][output]
  logic  [NumPorts-1:0][NumPorts-1:0] sa_req;
  logic  [NumPorts-1:0][NumVC-1:0]    sa_vc_oh;
  // [output][input]
  logic  [NumPorts-1:0][NumPorts-1:0] req_per_out;
  logic  [NumPorts-1:0]               gnt_v;
  logic  [NumPorts-1:0][NumPorts-1:0] gnt_oh;
  logic  [NumPorts-1:0]               read_v;
  flit_t [NumPorts-1:0]               sel_head;
  vc_idx_t [NumPorts-1:0]             consume_id;

  // ====================
  // per input
  // ====================

  for (genvar i = 0; i < NumPorts; i++) begin : gen_in
    vc_input_port #(
      .VCDepth ( VCDepth )
    ) i_input_port (
      .clk_i        ( clk_i          ),
      .rst_n_i      ( rst_n_i        ),
      .data_v_i     ( data_v_i[i]    ),
      .data_i       ( data_i[i]      ),
      .read_v_i     ( read_v[i]      ),
      .read_vc_oh_i ( sa_vc_oh[i]    ),
      .head_v_o     ( head_v[i]      ),
      .head_o       ( head[i]        ),
      .credit_v_o   ( credit_v_o[i]  ),
      .credit_id_o  ( credit_id_o[i] )
    );

    sa_local i_sa_local (
      .clk_i         ( clk_i       ),
      .rst_n_i       ( rst_n_i     ),
      .head_v_i      ( head_v[i]   ),
      .head_i        ( head[i]     ),
      .vc_not_full_i ( vc_not_full ),
      .sent_i        ( read_v[i]   ),
      .req_o         ( sa_req[i]   ),
      .vc_oh_o       ( sa_vc_oh[i] )
    );

    // any output granting this input means the flit is read and sent
    always_comb begin
      read_v[i] = 1'b0;
      for (int o = 0; o < NumPorts; o++) begin
        read_v[i] = read_v[i] | (gnt_v[o] & gnt_oh[o][i]);
      end
    end

    // head the local stage picked, needed for the consume id
    always_comb begin
      sel_head[i] = '0;
      for (int v = 0; v < NumVC; v++) begin
        if (sa_vc_oh[i][v]) begin
          sel_head[i] = head[i][v];
        end
      end
    end
  end

  // ====================
  // per output
  // ====================

  for (genvar o = 0; o < NumPorts; o++) begin : gen_out
    for (genvar i = 0; i < NumPorts; i++) begin : gen_transpose
      assign req_per_out[o][i] = sa_req[i][o];
    end

    sa_global i_sa_global (
      .clk_i    ( clk_i          ),
      .rst_n_i  ( rst_n_i        ),
      .req_i    ( req_per_out[o] ),
      .gnt_v_o  ( gnt_v[o]       ),
      .gnt_oh_o ( gnt_oh[o]      )
    );

    // fixed VC, the flit keeps its own vc id downstream
    always_comb begin
      consume_id[o] = '0;
      for (int i = 0; i < NumPorts; i++) begin
        if (gnt_oh[o][i]) begin
          consume_id[o] = sel_head[i].vc_id;
        end
      end
    end

    credit_counter #(
      .VCDepth ( VCDepth )
    ) i_credit_counter (
      .clk_i         ( clk_i          ),
      .rst_n_i       ( rst_n_i        ),
      .credit_v_i    ( credit_v_i[o]  ),
      .credit_id_i   ( credit_id_i[o] ),
      .consume_v_i   ( gnt_v[o]       ),
      .consume_id_i  ( consume_id[o]  ),
      .vc_not_full_o ( vc_not_full[o] )
    );
  end

  // ====================
  // switch traversal
  // ====================

  st_switch i_st_switch (
    .clk_i        ( clk_i    ),
    .rst_n_i      ( rst_n_i  ),
    .gnt_v_i      ( gnt_v    ),
    .gnt_oh_i     ( gnt_oh   ),
    .read_vc_oh_i ( sa_vc_oh ),
    .head_i       ( head     ),
    .data_v_o     ( data_v_o ),
    .data_o       ( data_o   )
  );

endmodule

`default_nettype wire

//--- verification/tb_vc_router.sv
// testbench of the virtual-channel router
// upstream traffic model with credits, downstream credit return model,
// scoreboard queues per output, source and VC, checks and watchdog

`timescale 1ns/1ps
`default_nettype none

module tb_vc_router import vc_router_pkg::*; ;

  localparam int ClkPeriod  = 8;
  localparam int VCDepth    = 2;
  localparam int IdleCycles = 5;
  localparam int BpCycles   = 30;
  localparam int FairCycles = 60;
  localparam int RandCycles = 400;
  localparam int DrainLimit = 300;
  localparam int FairOut    = 2;
  // reset, phases and seven drains at their limit
  localparam int TestCycles = 3 + IdleCycles + NumPorts + BpCycles + FairCycles
                              + RandCycles + 7 * DrainLimit;
  localparam int NumQueues  = NumPorts * NumPorts * NumVC;

  logic                   clk_i;
  logic                   rst_n_i;
  logic [NumPorts-1:0]    data_v_i;
  flit_t [NumPorts-1:0]   data_i;
  logic [NumPorts-1:0]    credit_v_o;
  vc_idx_t [NumPorts-1:0] credit_id_o;
  logic [NumPorts-1:0]    data_v_o;
  flit_t [NumPorts-1:0]   data_o;
  logic [NumPorts-1:0]    credit_v_i;
  vc_idx_t [NumPorts-1:0] credit_id_i;

  int    seed = 17;
  int    cycle = 0;
  int    errors = 0;
  int    sent_cnt = 0;
  int    recv_total = 0;
  int    in_flight = 0;
  string phase = "reset";
  logic  check_latency = 1'b0;
  logic  fair_check = 1'b0;
  int    last_src = -1;
  logic [NumPorts-1:0] hold_mask = '0;

  // upstream credits per input VC, downstream slots in use per output VC
  int up_cred [NumPorts][NumVC];
  int outstanding [NumPorts][NumVC];
  int recv_cnt [NumPorts][NumVC];
  logic [DataWidth-$bits(port_idx_t)-1:0] seq [NumPorts];

  // expected flits, indexed by output, source port and VC
  flit_t   exp_q [NumQueues][$];
  int      exp_cyc_q [NumQueues][$];
  vc_idx_t ret_q [NumPorts][$];

  vc_router #(
    .VCDepth ( VCDepth )
  ) DUT (
    .clk_i       ( clk_i       ),
    .rst_n_i     ( rst_n_i     ),
    .data_v_i    ( data_v_i    ),
    .data_i      ( data_i      ),
    .credit_v_o  ( credit_v_o  ),
    .credit_id_o ( credit_id_o ),
    .data_v_o    ( data_v_o    ),
    .data_o      ( data_o      ),
    .credit_v_i  ( credit_v_i  ),
    .credit_id_i ( credit_id_i )
  );

  initial begin
    clk_i = 1'b0;
    forever #(ClkPeriod / 2) clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycle <= cycle + 1;
  end

  function automatic int queue_index(int o, int s, int v);
    return (o * NumPorts + s) * NumVC + v;
  endfunction

  // one clock of upstream and downstream driving
  task automatic step(input logic [NumPorts-1:0] want,
                      input port_idx_t [NumPorts-1:0] dst,
                      input vc_idx_t [NumPorts-1:0] vc);
    flit_t f;
    int    idx;
    @(posedge clk_i);
    #1;
    for (int p = 0; p < NumPorts; p++) begin
      data_v_i[p] = 1'b0;
      if (want[p] && up_cred[p][vc[p]] > 0) begin
        f.dst_port = dst[p];
        f.vc_id    = vc[p];
        f.payload  = {port_idx_t'(p), seq[p]};
        seq[p]++;
        up_cred[p][vc[p]]--;
        data_v_i[p] = 1'b1;
        data_i[p]   = f;
        idx = queue_index(dst[p], p, vc[p]);
        exp_q[idx].push_back(f);
        exp_cyc_q[idx].push_back(cycle);
        in_flight++;
        sent_cnt++;
      end
    end
    // downstream frees a slot now and then, one per cycle at most
    for (int o = 0; o < NumPorts; o++) begin
      credit_v_i[o] = 1'b0;
      if (!hold_mask[o] && ret_q[o].size() > 0 && ($unsigned($random(seed)) % 3) == 0) begin
        credit_v_i[o]  = 1'b1;
        credit_id_i[o] = ret_q[o].pop_front();
        outstanding[o][credit_id_i[o]]--;
      end
    end
  endtask

  task automatic drain();
    int   waited;
    logic busy;
    waited = 0;
    busy   = 1'b1;
    while (busy && waited < DrainLimit) begin
      step('0, '0, '0);
      waited++;
      busy = (in_flight != 0);
      for (int o = 0; o < NumPorts; o++) begin
        if (ret_q[o].size() != 0) begin
          busy = 1'b1;
        end
      end
    end
    assert (!busy) else begin
      errors++;
      $display("%s: router did not drain within %0d cycles, %0d flits still inside",
               phase, DrainLimit, in_flight);
    end
  endtask

  // ====================
  // output monitor
  // ====================

  always @(negedge clk_i) begin : monitor
    flit_t   f;
    flit_t   exp;
    int      s;
    int      v;
    int      idx;
    int      oidx;
    int      sent_cyc;
    int      from_src [NumPorts];
    vc_idx_t vc_src [NumPorts];
    if (rst_n_i) begin
      // nothing inside the router means nothing may come out
      if (in_flight == 0) begin
        assert (data_v_o == '0 && credit_v_o == '0) else begin
          errors++;
          $display("Fail %s quiet: expected 0/0 actual %b/%b", phase, data_v_o, credit_v_o);
        end
      end
      for (int p = 0; p < NumPorts; p++) begin
        from_src[p] = 0;
        vc_src[p]   = '0;
      end
      for (int o = 0; o < NumPorts; o++) begin
        if (data_v_o[o]) begin
          f   = data_o[o];
          s   = int'(f.payload[DataWidth-1 -: $bits(port_idx_t)]);
          v   = int'(f.vc_id);
          idx = queue_index(o, s, v);
          from_src[s]++;
          vc_src[s] = f.vc_id;
          recv_total++;
          in_flight--;
          assert (exp_q[idx].size() > 0) else begin
            errors++;
            $display("%s: output %0d carried a flit that was never sent: %h", phase, o, f);
          end
          if (exp_q[idx].size() > 0) begin
            if (fair_check && o == FairOut && s < 2) begin
              oidx = queue_index(o, 1 - s, v);
              assert (!(s == last_src && exp_cyc_q[oidx].size() > 0
                        && exp_cyc_q[oidx][0] <= cycle - 2)) else begin
                errors++;
                $display("%s: input %0d won output %0d twice while input %0d waited",
                         phase, s, o, 1 - s);
              end
              last_src = s;
            end
            exp      = exp_q[idx].pop_front();
            sent_cyc = exp_cyc_q[idx].pop_front();
            assert (f == exp) else begin
              errors++;
              $display("Fail %s order: expected %h actual %h", phase, exp, f);
            end
            if (check_latency) begin
              assert (cycle - sent_cyc == 2) else begin
                errors++;
                $display("Fail %s latency: expected 2 actual %0d", phase, cycle - sent_cyc);
              end
            end
          end
          recv_cnt[o][v]++;
          outstanding[o][v]++;
          ret_q[o].push_back(f.vc_id);
          assert (outstanding[o][v] <= VCDepth) else begin
            errors++;
            $display("Fail %s slots in use: expected at most %0d actual %0d",
                     phase, VCDepth, outstanding[o][v]);
          end
        end
      end
      // one credit pulse per departing flit, on its own input and VC
      for (int p = 0; p < NumPorts; p++) begin
        assert (from_src[p] == int'(credit_v_o[p])) else begin
          errors++;
          $display("Fail %s credit pulse: expected %0d actual %0d",
                   phase, from_src[p], credit_v_o[p]);
        end
        if (credit_v_o[p]) begin
          assert (credit_id_o[p] == vc_src[p]) else begin
            errors++;
            $display("Fail %s credit id: expected %0d actual %0d",
                     phase, vc_src[p], credit_id_o[p]);
          end
          up_cred[p][credit_id_o[p]]++;
        end
      end
    end
  end

  // ====================
  // test sequence
  // ====================

  initial begin : main
    logic [NumPorts-1:0]    want;
    port_idx_t [NumPorts-1:0] dst;
    vc_idx_t [NumPorts-1:0] vc;
    rst_n_i     = 1'b0;
    data_v_i    = '0;
    data_i      = '0;
    credit_v_i  = '0;
    credit_id_i = '0;
    for (int p = 0; p < NumPorts; p++) begin
      seq[p] = '0;
      for (int v = 0; v < NumVC; v++) begin
        up_cred[p][v]     = VCDepth;
        outstanding[p][v] = 0;
        recv_cnt[p][v]    = 0;
      end
    end
    repeat (3) @(posedge clk_i);
    #1;
    rst_n_i = 1'b1;

    phase = "idle";
    repeat (IdleCycles) step('0, '0, '0);

    // one flit at a time through an empty router
    phase = "single";
    check_latency = 1'b1;
    for (int p = 0; p < NumPorts; p++) begin
      want    = '0;
      dst     = '0;
      vc      = '0;
      want[p] = 1'b1;
      dst[p]  = port_idx_t'(p + 1);
      vc[p]   = vc_idx_t'(p);
      step(want, dst, vc);
      drain();
    end
    check_latency = 1'b0;

    // output 0 gets no credits back, output 1 keeps flowing
    phase = "back_pressure";
    hold_mask = 4'b0001;
    for (int o = 0; o < NumPorts; o++) begin
      for (int v = 0; v < NumVC; v++) begin
        recv_cnt[o][v] = 0;
      end
    end
    for (int c = 0; c < BpCycles; c++) begin
      want = '1;
      for (int p = 0; p < NumPorts; p++) begin
        dst[p] = (p < 2) ? port_idx_t'(0) : port_idx_t'(1);
        vc[p]  = vc_idx_t'(c + p);
      end
      step(want, dst, vc);
    end
    for (int v = 0; v < NumVC; v++) begin
      assert (recv_cnt[0][v] == VCDepth) else begin
        errors++;
        $display("Fail %s held output: expected %0d actual %0d", phase, VCDepth, recv_cnt[0][v]);
      end
    end
    assert (recv_cnt[1][0] + recv_cnt[1][1] > 0) else begin
      errors++;
      $display("%s: output 1 stalled while only output 0 was held", phase);
    end
    hold_mask = '0;
    drain();
    assert (recv_cnt[0][0] > VCDepth && recv_cnt[0][1] > VCDepth) else begin
      errors++;
      $display("%s: output 0 did not resume after its credits came back", phase);
    end

    // inputs 0 and 1 fight for one output on VC 0
    phase = "fairness";
    fair_check = 1'b1;
    last_src = -1;
    for (int c = 0; c < FairCycles; c++) begin
      want = 4'b0011;
      dst  = {NumPorts{port_idx_t'(FairOut)}};
      vc   = '0;
      step(want, dst, vc);
    end
    drain();
    fair_check = 1'b0;

    phase = "random";
    for (int c = 0; c < RandCycles; c++) begin
      for (int p = 0; p < NumPorts; p++) begin
        want[p] = $random(seed) & 1;
        dst[p]  = port_idx_t'($unsigned($random(seed)));
        vc[p]   = vc_idx_t'($unsigned($random(seed)));
      end
      step(want, dst, vc);
    end
    drain();

    for (int i = 0; i < NumQueues; i++) begin
      assert (exp_q[i].size() == 0) else begin
        errors++;
        $display("%0d flits of scoreboard queue %0d were never delivered", exp_q[i].size(), i);
      end
    end

    $display("checks failed: %0d, flits sent: %0d, flits received: %0d",
             errors, sent_cnt, recv_total);
    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

  initial begin : watchdog
    #(TestCycles * ClkPeriod + 1000);
    $display("watchdog expired, the run did not finish within %0d cycles", TestCycles);
    $display("TB FAILED");
    $finish;
  end

endmodule

`default_nettype wire

//--- list.f
source/vc_router_pkg.sv
source/vc_buffer.sv
source/vc_input_port.sv
source/sa_local.sv
source/sa_global.sv
source/credit_counter.sv
source/st_switch.sv
source/vc_router.sv
verification/tb_vc_router.sv

//--- Bender.yml
package:
  name: vc_router

sources:
  - files:
      - source/vc_router_pkg.sv
      - source/vc_buffer.sv
      - source/vc_input_port.sv
      - source/sa_local.sv
      - source/sa_global.sv
      - source/credit_counter.sv
      - source/st_switch.sv
      - source/vc_router.sv
  - target: test
    files:
      - verification/tb_vc_router.sv
